/* rv_isa_pkg.sv */
// RV64IM ISA encoding definitions
// Major opcodes, funct3/funct7 values and architectural widths

package rv_isa_pkg;

    localparam int INST_W    = 32;
    localparam int XLEN      = 64;  // Data path width
    localparam int REG_IDX_W = 5;

    typedef logic [INST_W-1:0] inst_t;

    // Kept major opcodes, SYSTEM/MISC-MEM/AMO are absent on purpose
    typedef enum logic [6:0] {
        OP_LOAD    = 7'b0000011,
        OP_OP_IMM  = 7'b0010011,
        OP_AUIPC   = 7'b0010111,
        OP_IMM_32  = 7'b0011011,
        OP_STORE   = 7'b0100011,
        OP_OP      = 7'b0110011,
        OP_LUI     = 7'b0110111,
        OP_OP_32   = 7'b0111011,
        OP_BRANCH  = 7'b1100011,
        OP_JALR    = 7'b1100111,
        OP_JAL     = 7'b1101111
    } opcode_e;

    // Arithmetic funct3, shared by OP/OP-IMM and the word forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Load widths, bit 2 selects zero extension
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LD  = 3'b011;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_LWU = 3'b110;

    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;
    localparam logic [2:0] F3_SD = 3'b011;

    localparam logic [6:0] F7_STD    = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;  // SUB and arithmetic shifts
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

endpackage

/* decode_pkg.sv */
// Decoder output definitions
// ALU operation, jump condition, immediate format and the decoded/trap records

package decode_pkg;

    import rv_isa_pkg::*;

    // Encodings follow the existing execute stage
    typedef enum logic [4:0] {
        ALU_ADD    = 5'd0,
        ALU_SUB    = 5'd1,
        ALU_AND    = 5'd2,
        ALU_OR     = 5'd3,
        ALU_XOR    = 5'd4,
        ALU_SLL    = 5'd5,
        ALU_SRL    = 5'd6,
        ALU_SRA    = 5'd7,
        ALU_SLT    = 5'd8,
        ALU_SLTU   = 5'd9,
        ALU_MUL    = 5'd10,
        ALU_MULH   = 5'd11,
        ALU_MULHSU = 5'd12,
        ALU_MULHU  = 5'd13,
        ALU_DIV    = 5'd14,
        ALU_DIVU   = 5'd15,
        ALU_REM    = 5'd16,
        ALU_REMU   = 5'd17,
        ALU_MULW   = 5'd18,
        ALU_DIVW   = 5'd19,
        ALU_DIVUW  = 5'd20,
        ALU_REMW   = 5'd21,
        ALU_REMUW  = 5'd22,
        ALU_ADDW   = 5'd23,
        ALU_SLLW   = 5'd24,
        ALU_SRLW   = 5'd25,
        ALU_SRAW   = 5'd26,
        ALU_SUBW   = 5'd27,
        ALU_NOP    = 5'd31
    } alu_op_e;

    typedef enum logic [1:0] {
        JUMP_NO      = 2'd0,
        JUMP_YES     = 2'd1,
        JUMP_ALU_EQZ = 2'd2,  // Taken when ALU result is zero
        JUMP_ALU_NEZ = 2'd3
    } jump_cond_e;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_SHAMT,   // 6-bit shift amount
        IMM_SHAMTW   // 5-bit shift amount, word shifts
    } imm_fmt_e;

    typedef enum logic [1:0] {
        MEM_B,
        MEM_H,
        MEM_W,
        MEM_D
    } mem_size_e;

    typedef struct packed {
        logic [REG_IDX_W-1:0] rs1;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] rd;
        logic                 en_rs1;
        logic                 en_rs2;
        logic                 en_rd;
        logic [XLEN-1:0]      immed;
        alu_op_e              alu_op;
        logic                 alu_use_immed;
        logic                 alu_width_32;
        jump_cond_e           jump_if;
        logic                 jump_absolute;  // JALR target from rs1
        logic                 is_load;
        logic                 is_store;
        mem_size_e            mem_size;
        logic                 mem_signed;
        logic                 reg_write;
    } decoded_inst_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] cause;
        logic [XLEN-1:0] tval;
    } trap_info_t;

    localparam logic [XLEN-1:0] MCAUSE_ILLEGAL_INST = 64'd2;

endpackage

/* imm_gen.sv */
// Immediate generator
// Builds the 64-bit immediate for the format picked by the control decoder

`timescale 1ns/1ps

module imm_gen
    import rv_isa_pkg::*;
    import decode_pkg::*;
(
    input  inst_t           inst,
    input  imm_fmt_e        imm_fmt,
    output logic [XLEN-1:0] immed
);

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_shamt;
    logic [XLEN-1:0] imm_shamtw;

    assign imm_i = {{(XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s = {{(XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{(XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                    inst[11:8], 1'b0};
    assign imm_u = {{(XLEN-32){inst[31]}}, inst[31:12], 12'b0};  // Upper 20 bits
    assign imm_j = {{(XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                    inst[30:21], 1'b0};

    // Shift amounts are unsigned
    assign imm_shamt  = {{(XLEN-6){1'b0}}, inst[25:20]};
    assign imm_shamtw = {{(XLEN-5){1'b0}}, inst[24:20]};

    always_comb begin
        case (imm_fmt)
            IMM_I:      immed = imm_i;
            IMM_S:      immed = imm_s;
            IMM_B:      immed = imm_b;
            IMM_U:      immed = imm_u;
            IMM_J:      immed = imm_j;
            IMM_SHAMT:  immed = imm_shamt;
            IMM_SHAMTW: immed = imm_shamtw;
            default:    immed = '0;  // IMM_NONE
        endcase
    end

endmodule

/* alu_op_decoder.sv */
// ALU operation decoder
// Maps opcode, funct3 and funct7 to an ALU operation and flags undefined encodings

`timescale 1ns/1ps

module alu_op_decoder
    import rv_isa_pkg::*;
    import decode_pkg::*;
(
    input  inst_t   inst,
    output alu_op_e alu_op,
    output logic    alu_illegal
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        alu_op      = ALU_NOP;
        alu_illegal = 1'b0;
        case (opcode)
            OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_STORE: alu_op = ALU_ADD;  // Address adds
            OP_BRANCH: begin
                case (funct3)
                    F3_BEQ, F3_BNE:   alu_op = ALU_SUB;
                    F3_BLT, F3_BGE:   alu_op = ALU_SLT;
                    F3_BLTU, F3_BGEU: alu_op = ALU_SLTU;
                    default:          alu_op = ALU_NOP;
                endcase
            end
            OP_OP_IMM: begin
                // funct7 bit 0 is shamt[5] on RV64, only the top six bits decode
                case (funct3)
                    F3_ADD_SUB: alu_op = ALU_ADD;
                    F3_SLT:     alu_op = ALU_SLT;
                    F3_SLTU:    alu_op = ALU_SLTU;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_OR:      alu_op = ALU_OR;
                    F3_AND:     alu_op = ALU_AND;
                    F3_SLL: begin
                        alu_op      = ALU_SLL;
                        alu_illegal = (funct7[6:1] != F7_STD[6:1]);
                    end
                    default: begin
                        if (funct7[6:1] == F7_STD[6:1])
                            alu_op = ALU_SRL;
                        else if (funct7[6:1] == F7_ALT[6:1])
                            alu_op = ALU_SRA;
                        else
                            alu_illegal = 1'b1;
                    end
                endcase
            end
            OP_OP: begin
                case ({funct7, funct3})
                    {F7_STD, F3_ADD_SUB}:    alu_op = ALU_ADD;
                    {F7_STD, F3_SLL}:        alu_op = ALU_SLL;
                    {F7_STD, F3_SLT}:        alu_op = ALU_SLT;
                    {F7_STD, F3_SLTU}:       alu_op = ALU_SLTU;
                    {F7_STD, F3_XOR}:        alu_op = ALU_XOR;
                    {F7_STD, F3_SRL_SRA}:    alu_op = ALU_SRL;
                    {F7_STD, F3_OR}:         alu_op = ALU_OR;
                    {F7_STD, F3_AND}:        alu_op = ALU_AND;
                    {F7_ALT, F3_ADD_SUB}:    alu_op = ALU_SUB;
                    {F7_ALT, F3_SRL_SRA}:    alu_op = ALU_SRA;
                    {F7_MULDIV, F3_ADD_SUB}: alu_op = ALU_MUL;
                    {F7_MULDIV, F3_SLL}:     alu_op = ALU_MULH;
                    {F7_MULDIV, F3_SLT}:     alu_op = ALU_MULHSU;
                    {F7_MULDIV, F3_SLTU}:    alu_op = ALU_MULHU;
                    {F7_MULDIV, F3_XOR}:     alu_op = ALU_DIV;
                    {F7_MULDIV, F3_SRL_SRA}: alu_op = ALU_DIVU;
                    {F7_MULDIV, F3_OR}:      alu_op = ALU_REM;
                    {F7_MULDIV, F3_AND}:     alu_op = ALU_REMU;
                    default:                 alu_illegal = 1'b1;
                endcase
            end
            OP_IMM_32: begin
                case (funct3)
                    F3_ADD_SUB: alu_op = ALU_ADDW;  // ADDIW
                    F3_SLL: begin
                        alu_op      = ALU_SLLW;
                        alu_illegal = (funct7 != F7_STD);
                    end
                    F3_SRL_SRA: begin
                        if (funct7 == F7_STD)
                            alu_op = ALU_SRLW;
                        else if (funct7 == F7_ALT)
                            alu_op = ALU_SRAW;
                        else
                            alu_illegal = 1'b1;
                    end
                    default: alu_illegal = 1'b1;
                endcase
            end
            OP_OP_32: begin
                case ({funct7, funct3})
                    {F7_STD, F3_ADD_SUB}:    alu_op = ALU_ADDW;
                    {F7_STD, F3_SLL}:        alu_op = ALU_SLLW;
                    {F7_STD, F3_SRL_SRA}:    alu_op = ALU_SRLW;
                    {F7_ALT, F3_ADD_SUB}:    alu_op = ALU_SUBW;
                    {F7_ALT, F3_SRL_SRA}:    alu_op = ALU_SRAW;
                    {F7_MULDIV, F3_ADD_SUB}: alu_op = ALU_MULW;
                    {F7_MULDIV, F3_XOR}:     alu_op = ALU_DIVW;
                    {F7_MULDIV, F3_SRL_SRA}: alu_op = ALU_DIVUW;
                    {F7_MULDIV, F3_OR}:      alu_op = ALU_REMW;
                    {F7_MULDIV, F3_AND}:     alu_op = ALU_REMUW;
                    default:                 alu_illegal = 1'b1;
                endcase
            end
            default: alu_op = ALU_NOP;  // LUI and unknown opcodes
        endcase
    end

endmodule

/* control_decoder.sv */
// Opcode-level control decoder
// Register enables, memory and jump controls, immediate format and illegal-instruction trap

`timescale 1ns/1ps

module control_decoder
    import rv_isa_pkg::*;
    import decode_pkg::*;
(
    input  inst_t         inst,
    input  logic          alu_illegal,
    output decoded_inst_t fields,
    output imm_fmt_e      imm_fmt,
    output trap_info_t    trap
);

    opcode_e       opcode;
    logic [2:0]    funct3;
    logic          op_bad;
    logic          f3_bad;
    logic          illegal;
    decoded_inst_t raw;

    assign opcode  = opcode_e'(inst[6:0]);
    assign funct3  = inst[14:12];
    assign illegal = op_bad | f3_bad | alu_illegal;

    always_comb begin
        raw     = '0;  // immed and alu_op are filled in at the top
        raw.rs1 = inst[19:15];
        raw.rs2 = inst[24:20];
        raw.rd  = inst[11:7];
        imm_fmt = IMM_NONE;
        op_bad  = 1'b0;
        f3_bad  = 1'b0;
        case (opcode)
            OP_LUI, OP_AUIPC: begin
                imm_fmt                          = IMM_U;
                raw.reg_write                    = 1'b1;
                {raw.en_rs1, raw.en_rs2, raw.en_rd} = 3'b001;
            end
            OP_JAL: begin
                imm_fmt                          = IMM_J;
                raw.reg_write                    = 1'b1;
                raw.jump_if                      = JUMP_YES;
                {raw.en_rs1, raw.en_rs2, raw.en_rd} = 3'b001;
            end
            OP_JALR: begin
                imm_fmt                          = IMM_I;
                raw.reg_write                    = 1'b1;
                raw.jump_if                      = JUMP_YES;
                raw.jump_absolute                = 1'b1;
                {raw.en_rs1, raw.en_rs2, raw.en_rd} = 3'b101;
            end
            OP_BRANCH: begin
                imm_fmt                          = IMM_B;
                {raw.en_rs1, raw.en_rs2, raw.en_rd} = 3'b110;
                case (funct3)
                    F3_BEQ, F3_BGE, F3_BGEU: raw.jump_if = JUMP_ALU_EQZ;  // SUB zero or SLT false
                    F3_BNE, F3_BLT, F3_BLTU: raw.jump_if = JUMP_ALU_NEZ;
                    default:                 f3_bad      = 1'b1;
                endcase
            end
            OP_LOAD: begin
                imm_fmt                          = IMM_I;
                raw.reg_write                    = 1'b1;
                raw.is_load                      = 1'b1;
                {raw.en_rs1, raw.en_rs2, raw.en_rd} = 3'b101;
                case (funct3)
                    F3_LB:   {raw.mem_size, raw.mem_signed} = {MEM_B, 1'b1};
                    F3_LH:   {raw.mem_size, raw.mem_signed} = {MEM_H, 1'b1};
                    F3_LW:   {raw.mem_size, raw.mem_signed} = {MEM_W, 1'b1};
                    F3_LD:   {raw.mem_size, raw.mem_signed} = {MEM_D, 1'b1};
                    F3_LBU:  {raw.mem_size, raw.mem_signed} = {MEM_B, 1'b0};
                    F3_LHU:  {raw.mem_size, raw.mem_signed} = {MEM_H, 1'b0};
                    F3_LWU:  {raw.mem_size, raw.mem_signed} = {MEM_W, 1'b0};
                    default: f3_bad = 1'b1;
                endcase
            end
            OP_STORE: begin
                imm_fmt                          = IMM_S;
                raw.is_store                     = 1'b1;
                {raw.en_rs1, raw.en_rs2, raw.en_rd} = 3'b110;
                case (funct3)
                    F3_SB:   raw.mem_size = MEM_B;
                    F3_SH:   raw.mem_size = MEM_H;
                    F3_SW:   raw.mem_size = MEM_W;
                    F3_SD:   raw.mem_size = MEM_D;
                    default: f3_bad = 1'b1;
                endcase
            end
            OP_OP_IMM, OP_IMM_32: begin
                raw.alu_use_immed                = 1'b1;
                raw.reg_write                    = 1'b1;
                raw.alu_width_32                 = (opcode == OP_IMM_32);
                {raw.en_rs1, raw.en_rs2, raw.en_rd} = 3'b101;
                if (funct3 == F3_SLL || funct3 == F3_SRL_SRA)
                    imm_fmt = (opcode == OP_IMM_32) ? IMM_SHAMTW : IMM_SHAMT;
                else
                    imm_fmt = IMM_I;
            end
            OP_OP, OP_OP_32: begin
                raw.reg_write                    = 1'b1;
                raw.alu_width_32                 = (opcode == OP_OP_32);
                {raw.en_rs1, raw.en_rs2, raw.en_rd} = 3'b111;
            end
            default: op_bad = 1'b1;  // SYSTEM, MISC-MEM, AMO and unknown
        endcase
    end

    // A trapping instruction must not touch registers or memory
    always_comb begin
        fields = raw;
        if (illegal) begin
            fields.en_rs1    = 1'b0;
            fields.en_rs2    = 1'b0;
            fields.en_rd     = 1'b0;
            fields.reg_write = 1'b0;
            fields.is_load   = 1'b0;
            fields.is_store  = 1'b0;
        end
    end

    always_comb begin
        trap.valid = illegal;
        trap.cause = illegal ? MCAUSE_ILLEGAL_INST : '0;
        trap.tval  = illegal ? XLEN'(inst) : '0;  // Zero-extended instruction word
    end

endmodule

/* inst_decoder.sv */
// Registered RV64IM instruction decode stage
// Decoded record and trap record appear one cycle after a valid instruction

`timescale 1ns/1ps

module inst_decoder
    import rv_isa_pkg::*;
    import decode_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          valid,
    input  inst_t         inst,
    output logic          dec_valid,
    output decoded_inst_t dec,
    output trap_info_t    trap
);

    decoded_inst_t   fields;
    decoded_inst_t   dec_next;
    trap_info_t      trap_next;
    imm_fmt_e        imm_fmt;
    alu_op_e         alu_op;
    logic            alu_illegal;
    logic [XLEN-1:0] immed;

    alu_op_decoder u_alu_op_decoder (
        .inst        (inst),
        .alu_op      (alu_op),
        .alu_illegal (alu_illegal)
    );

    control_decoder u_control_decoder (
        .inst        (inst),
        .alu_illegal (alu_illegal),
        .fields      (fields),
        .imm_fmt     (imm_fmt),
        .trap        (trap_next)
    );

    imm_gen u_imm_gen (
        .inst    (inst),
        .imm_fmt (imm_fmt),
        .immed   (immed)
    );

    always_comb begin
        dec_next        = fields;
        dec_next.immed  = immed;
        dec_next.alu_op = alu_op;
    end

    // Payload holds its last value while valid is low
    always_ff @(posedge clk) begin
        if (valid)
            dec <= dec_next;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
            trap      <= '0;
        end else begin
            dec_valid  <= valid;
            trap       <= trap_next;
            trap.valid <= valid & trap_next.valid;  // No trap from an idle cycle
        end
    end

endmodule

/* tb_vectors.svh */
// Decode vector table for the instruction decoder testbench
// Columns: instruction, enables rs1/rs2/rd, immediate, ALU op, jump condition, mem size, flags

task automatic load_vectors();
    // R-type and M extension
    add_vec(32'h00b50633, 3'b111, 64'h0, ALU_ADD,    JUMP_NO, MEM_B, F_WR);
    add_vec(32'h40b50633, 3'b111, 64'h0, ALU_SUB,    JUMP_NO, MEM_B, F_WR);
    add_vec(32'h40b55633, 3'b111, 64'h0, ALU_SRA,    JUMP_NO, MEM_B, F_WR);
    add_vec(32'h00b53633, 3'b111, 64'h0, ALU_SLTU,   JUMP_NO, MEM_B, F_WR);
    add_vec(32'h02b50633, 3'b111, 64'h0, ALU_MUL,    JUMP_NO, MEM_B, F_WR);
    add_vec(32'h02b52633, 3'b111, 64'h0, ALU_MULHSU, JUMP_NO, MEM_B, F_WR);
    add_vec(32'h02b55633, 3'b111, 64'h0, ALU_DIVU,   JUMP_NO, MEM_B, F_WR);
    add_vec(32'h02b57633, 3'b111, 64'h0, ALU_REMU,   JUMP_NO, MEM_B, F_WR);
    add_vec(32'h00b5063b, 3'b111, 64'h0, ALU_ADDW,   JUMP_NO, MEM_B, F_WR | F_W32);
    add_vec(32'h40b5063b, 3'b111, 64'h0, ALU_SUBW,   JUMP_NO, MEM_B, F_WR | F_W32);
    add_vec(32'h40b5563b, 3'b111, 64'h0, ALU_SRAW,   JUMP_NO, MEM_B, F_WR | F_W32);
    add_vec(32'h02b5063b, 3'b111, 64'h0, ALU_MULW,   JUMP_NO, MEM_B, F_WR | F_W32);
    add_vec(32'h02b5763b, 3'b111, 64'h0, ALU_REMUW,  JUMP_NO, MEM_B, F_WR | F_W32);
    // Immediates: ADDI -16, SRAI 63, SLLIW 31, LUI, AUIPC, JAL -4
    add_vec(32'hff050613, 3'b101, 64'hffff_ffff_ffff_fff0, ALU_ADD, JUMP_NO, MEM_B, F_IMM | F_WR);
    add_vec(32'h43f55613, 3'b101, 64'h3f, ALU_SRA, JUMP_NO, MEM_B, F_IMM | F_WR);
    add_vec(32'h01f5161b, 3'b101, 64'h1f, ALU_SLLW, JUMP_NO, MEM_B, F_IMM | F_W32 | F_WR);
    add_vec(32'hfffff637, 3'b001, 64'hffff_ffff_ffff_f000, ALU_NOP, JUMP_NO, MEM_B, F_WR);
    add_vec(32'h12345617, 3'b001, 64'h0000_0000_1234_5000, ALU_ADD, JUMP_NO, MEM_B, F_WR);
    add_vec(32'hffdff0ef, 3'b001, 64'hffff_ffff_ffff_fffc, ALU_ADD, JUMP_YES, MEM_B, F_WR);
    add_vec(32'h010500e7, 3'b101, 64'h10, ALU_ADD, JUMP_YES, MEM_B, F_ABS | F_WR);
    // Stores SD -8 and SB 5
    add_vec(32'hfeb53c23, 3'b110, 64'hffff_ffff_ffff_fff8, ALU_ADD, JUMP_NO, MEM_D, F_ST);
    add_vec(32'h00b502a3, 3'b110, 64'h5, ALU_ADD, JUMP_NO, MEM_B, F_ST);
    // Loads LB, LHU, LWU, LD
    add_vec(32'h00450603, 3'b101, 64'h4, ALU_ADD, JUMP_NO, MEM_B, F_LD | F_SGN | F_WR);
    add_vec(32'hffe55603, 3'b101, 64'hffff_ffff_ffff_fffe, ALU_ADD, JUMP_NO, MEM_H, F_LD | F_WR);
    add_vec(32'h00856603, 3'b101, 64'h8, ALU_ADD, JUMP_NO, MEM_W, F_LD | F_WR);
    add_vec(32'h00053603, 3'b101, 64'h0, ALU_ADD, JUMP_NO, MEM_D, F_LD | F_SGN | F_WR);
    // Branches, BNE with a backward offset
    add_vec(32'h00b50863, 3'b110, 64'h10, ALU_SUB,  JUMP_ALU_EQZ, MEM_B, 0);
    add_vec(32'hfeb518e3, 3'b110, 64'hffff_ffff_ffff_fff0, ALU_SUB, JUMP_ALU_NEZ, MEM_B, 0);
    add_vec(32'h00b54863, 3'b110, 64'h10, ALU_SLT,  JUMP_ALU_NEZ, MEM_B, 0);
    add_vec(32'h00b55863, 3'b110, 64'h10, ALU_SLT,  JUMP_ALU_EQZ, MEM_B, 0);
    add_vec(32'h00b56863, 3'b110, 64'h10, ALU_SLTU, JUMP_ALU_NEZ, MEM_B, 0);
    add_vec(32'h00b57863, 3'b110, 64'h10, ALU_SLTU, JUMP_ALU_EQZ, MEM_B, 0);
    // Illegal: ECALL, FENCE, unknown opcode, bad OP funct, LOAD funct3 111
    add_vec(32'h00000073, 3'b000, 64'h0, ALU_NOP, JUMP_NO, MEM_B, F_TRAP);
    add_vec(32'h0ff0000f, 3'b000, 64'h0, ALU_NOP, JUMP_NO, MEM_B, F_TRAP);
    add_vec(32'h12345677, 3'b000, 64'h0, ALU_NOP, JUMP_NO, MEM_B, F_TRAP);
    add_vec(32'h40b51633, 3'b000, 64'h0, ALU_NOP, JUMP_NO, MEM_B, F_TRAP);
    add_vec(32'h00457603, 3'b000, 64'h4, ALU_ADD, JUMP_NO, MEM_B, F_TRAP);
endtask

/* tb_inst_decoder.sv */
// Testbench for the registered RV64IM decode stage
// Applies the vector table with random idle gaps, then checks gating and back-to-back issue

`timescale 1ns/1ps

module tb_inst_decoder
    import rv_isa_pkg::*;
    import decode_pkg::*;
();

    // Expectation flags used by the vector table
    localparam int F_IMM  = 1;
    localparam int F_W32  = 2;
    localparam int F_ABS  = 4;
    localparam int F_LD   = 8;
    localparam int F_ST   = 16;
    localparam int F_SGN  = 32;
    localparam int F_WR   = 64;
    localparam int F_TRAP = 128;

    localparam int TIMEOUT_CYCLES = 20;

    typedef struct packed {
        inst_t         inst;
        decoded_inst_t exp;
        logic          trap;
    } vector_t;

    logic          clk = 1'b0;
    logic          rst;
    logic          valid;
    inst_t         inst;
    logic          dec_valid;
    decoded_inst_t dec;
    trap_info_t    trap;

    vector_t vectors[$];
    int      seed;

    inst_decoder UUT (
        .clk       (clk),
        .rst       (rst),
        .valid     (valid),
        .inst      (inst),
        .dec_valid (dec_valid),
        .dec       (dec),
        .trap      (trap)
    );

    always #2 clk = ~clk;  // 4 ns period

    task automatic report_failure();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_dec(input string name, input decoded_inst_t got,
                             input decoded_inst_t exp);
        if (got !== exp) begin
            $display("error %s: got %h, expected %h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_trap(input string name, input trap_info_t got, input trap_info_t exp);
        if (got !== exp) begin
            $display("error %s: got %h, expected %h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error %s: got %h, expected %h", name, got, exp);
            report_failure();
        end
    endtask

    // Register indices come straight from the instruction fields
    task automatic add_vec(input inst_t w, input logic [2:0] en, input logic [XLEN-1:0] imm,
                           input alu_op_e op, input jump_cond_e jc, input mem_size_e ms,
                           input int flags);
        vector_t v;
        v                   = '0;
        v.inst              = w;
        v.exp.rs1           = w[19:15];
        v.exp.rs2           = w[24:20];
        v.exp.rd            = w[11:7];
        {v.exp.en_rs1, v.exp.en_rs2, v.exp.en_rd} = en;
        v.exp.immed         = imm;
        v.exp.alu_op        = op;
        v.exp.jump_if       = jc;
        v.exp.mem_size      = ms;
        v.exp.alu_use_immed = (flags & F_IMM) != 0;
        v.exp.alu_width_32  = (flags & F_W32) != 0;
        v.exp.jump_absolute = (flags & F_ABS) != 0;
        v.exp.is_load       = (flags & F_LD) != 0;
        v.exp.is_store      = (flags & F_ST) != 0;
        v.exp.mem_signed    = (flags & F_SGN) != 0;
        v.exp.reg_write     = (flags & F_WR) != 0;
        v.trap              = (flags & F_TRAP) != 0;
        vectors.push_back(v);
    endtask

    `include "tb_vectors.svh"

    function automatic trap_info_t expected_trap(input vector_t v);
        trap_info_t t;
        t = '0;
        if (v.trap) begin
            t.valid = 1'b1;
            t.cause = 64'd2;            // Illegal instruction
            t.tval  = {32'b0, v.inst};
        end
        return t;
    endfunction

    // Outputs settle at the edge and inputs change 1 ns later
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_vector(input int idx);
        vector_t v;
        int      gap;
        int      waited;
        v     = vectors[idx];
        gap   = {$random(seed)} % 3;
        valid = 1'b0;
        repeat (gap) step();
        valid = 1'b1;
        inst  = v.inst;
        step();
        valid  = 1'b0;
        waited = 1;
        while (!dec_valid) begin
            if (waited >= TIMEOUT_CYCLES) begin
                $display("Timeout: dec_valid never arrived for vector %0d", idx);
                report_failure();
            end
            step();
            waited++;
        end
        if (waited != 1) begin
            $display("Vector %0d: result came %0d cycles after its input, not 1", idx, waited);
            report_failure();
        end
        check_dec($sformatf("dec[%0d]", idx), dec, v.exp);
        check_trap($sformatf("trap[%0d]", idx), trap, expected_trap(v));
    endtask

    initial begin
        vector_t first;
        vector_t last;
        seed  = 13;
        rst   = 1'b1;
        valid = 1'b1;           // Illegal word offered while reset is held
        inst  = 32'h00000073;
        load_vectors();
        repeat (10) @(posedge clk);
        #1;
        rst   = 1'b0;
        valid = 1'b0;
        check_flag("dec_valid", dec_valid, 1'b0);
        check_flag("trap.valid", trap.valid, 1'b0);

        for (int i = 0; i < vectors.size(); i++)
            apply_vector(i);

        // ECALL with valid low raises no trap and dec holds
        last  = vectors[vectors.size() - 1];
        first = vectors[0];
        valid = 1'b0;
        inst  = 32'h00000073;
        step();
        check_flag("dec_valid", dec_valid, 1'b0);
        check_flag("trap.valid", trap.valid, 1'b0);
        check_dec("dec", dec, last.exp);

        // Back-to-back issue of a legal then an illegal word
        valid = 1'b1;
        inst  = first.inst;
        step();
        check_flag("dec_valid", dec_valid, 1'b1);
        check_dec("dec", dec, first.exp);
        check_trap("trap", trap, expected_trap(first));
        inst = last.inst;
        step();
        check_flag("dec_valid", dec_valid, 1'b1);
        check_dec("dec", dec, last.exp);
        check_trap("trap", trap, expected_trap(last));
        valid = 1'b0;
        step();
        check_flag("dec_valid", dec_valid, 1'b0);
        check_flag("trap.valid", trap.valid, 1'b0);

        $display("All tests passed");
        $finish;
    end

endmodule

/* tb.f */
+incdir+.
rv_isa_pkg.sv
decode_pkg.sv
imm_gen.sv
alu_op_decoder.sv
control_decoder.sv
inst_decoder.sv
tb_inst_decoder.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_inst_decoder
FILELIST  ?= tb.f

OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(wildcard *.sv) $(wildcard *.svh)
PASS_MSG  := All tests passed

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
